// ==== verilog/rram_cfg_pkg.sv ====
// One 16-bit SECDED range only, and an SPI frame is an 8-bit opcode over a 24-bit payload
package rram_cfg_pkg;

  localparam int data_w  = 16;
  localparam int chk_w   = 6;
  localparam int word_w  = data_w + chk_w;
  localparam int addr_w  = 12;
  localparam int op_w    = 8;
  localparam int pay_w   = 24;
  localparam int frame_w = op_w + pay_w;

  // Bit positions inside an op_ctrl payload
  localparam int ctrl_start_bit = 0;
  localparam int ctrl_rd_bit    = 1;
  localparam int ctrl_ecc_bit   = 2;

  typedef enum logic [op_w-1:0] {
    op_nop     = 8'h00,
    op_wr_addr = 8'h01,
    op_wr_data = 8'h02,
    op_ctrl    = 8'h03
  } spi_op_e;

  // Operation request, go is a one-cycle strobe
  typedef struct packed {
    logic              go;
    logic              rd;
    logic              use_ecc;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } rram_cmd_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic              corrected;
    logic              uncorrectable;
  } rram_result_t;

endpackage

// ==== verilog/rram_analog_pkg.sv ====
// Field set matches the macro pins kept here, and the pads drive the same bundle under bypass
package rram_analog_pkg;

  import rram_cfg_pkg::*;

  // Controls into the macro
  typedef struct packed {
    logic [addr_w-1:0] rram_addr;
    logic [word_w-1:0] di;
    logic              we;
    logic              wl_en;
    logic              bl_en;
    logic              sl_en;
    logic              sa_en;
  } analog_ctrl_t;

  // Sense amplifier return
  typedef struct packed {
    logic [word_w-1:0] sa_do;
    logic              sa_rdy;
  } sense_t;

endpackage

// ==== verilog/spi_cmd_port.sv ====
`timescale 1ns/10ps
// SPI mode 0 slave sampled by mclk, so each sclk phase must last at least 4 mclk cycles
module spi_cmd_port import rram_cfg_pkg::*; (
  input  logic         mclk,
  input  logic         rst_n,
  input  logic         sclk,
  input  logic         sc,
  input  logic         mosi,
  input  logic         busy,
  input  rram_result_t result,
  output logic         miso,
  output rram_cmd_t    cmd
);

  localparam int cnt_w = $clog2(frame_w) + 1;
  localparam int pad_w = frame_w - data_w - 3;

  logic [2:0]         sclk_s;
  logic [2:0]         sc_s;
  logic [1:0]         mosi_s;
  logic               sclk_rise;
  logic               sclk_fall;
  logic               sc_fall;
  logic               sc_rise;
  logic [cnt_w-1:0]   bit_cnt;
  logic [frame_w-1:0] rx_shift;
  logic [frame_w-1:0] tx_shift;
  logic [frame_w-1:0] frame_q;
  logic               frame_vld;
  logic               start_q;
  spi_op_e            frame_op;
  logic [pay_w-1:0]   frame_pay;

  //////////////////////////////
  // Pin synchronizers
  //////////////////////////////

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_s <= '0;
      sc_s   <= '1;
      mosi_s <= '0;
    end else begin
      sclk_s <= {sclk_s[1:0], sclk};
      sc_s   <= {sc_s[1:0], sc};
      mosi_s <= {mosi_s[0], mosi};
    end
  end

  // Edges of the synchronized pins
  assign sclk_rise = sclk_s[1] & ~sclk_s[2] & ~sc_s[1];
  assign sclk_fall = ~sclk_s[1] & sclk_s[2] & ~sc_s[1];
  assign sc_fall   = ~sc_s[1] & sc_s[2];
  assign sc_rise   = sc_s[1] & ~sc_s[2];

  //////////////////////////////
  // Shifters
  //////////////////////////////

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt   <= '0;
      tx_shift  <= '0;
      frame_vld <= 1'b0;
    end else begin
      frame_vld <= sc_rise && (bit_cnt == cnt_w'(frame_w));
      if (sc_fall) begin
        bit_cnt  <= '0;
        // Status shadow, MSB leaves first
        tx_shift <= {busy, result.corrected, result.uncorrectable, {pad_w{1'b0}}, result.data};
      end else begin
        // Saturate so long frames never wrap back to a valid count
        if (sclk_rise && (bit_cnt != '1)) begin
          bit_cnt <= bit_cnt + 1'b1;
        end
        if (sclk_fall) begin
          tx_shift <= {tx_shift[frame_w-2:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge mclk) begin
    if (sclk_rise) begin
      rx_shift <= {rx_shift[frame_w-2:0], mosi_s[1]};
    end
    if (sc_rise) begin
      frame_q <= rx_shift;
    end
  end

  assign miso = tx_shift[frame_w-1];

  //////////////////////////////
  // Frame decode
  //////////////////////////////

  assign frame_op  = spi_op_e'(frame_q[frame_w-1 -: op_w]);
  assign frame_pay = frame_q[pay_w-1:0];

  // Capture, decode and launch stages put go 3 mclk after the sc edge
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      cmd     <= '0;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      cmd.go  <= start_q;
      if (frame_vld) begin
        case (frame_op)
          op_wr_addr: cmd.addr <= frame_pay[addr_w-1:0];
          op_wr_data: cmd.data <= frame_pay[data_w-1:0];
          op_ctrl: begin
            cmd.rd      <= frame_pay[ctrl_rd_bit];
            cmd.use_ecc <= frame_pay[ctrl_ecc_bit];
            start_q     <= frame_pay[ctrl_start_bit];
          end
          // Status-only frame
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== verilog/ecc_codec.sv ====
`timescale 1ns/10ps
// SECDED over 16 bits corrects one error and only flags two, and bit 21 is the overall parity
module ecc_codec import rram_cfg_pkg::*; (
  input  logic              mclk,
  input  logic              rst_n,
  input  rram_cmd_t         cmd_in,
  input  logic [word_w-1:0] raw_word,
  input  logic              raw_valid,
  output rram_cmd_t         cmd_out,
  output logic [word_w-1:0] enc_word,
  output rram_result_t      result
);

  localparam int ham_w = chk_w - 1;

  // Hamming position of a data bit, skipping the power-of-two check slots
  function automatic logic [ham_w-1:0] data_pos(input int idx);
    logic [ham_w-1:0] pos;
    pos = ham_w'(3);
    for (int i = 0; i < idx; i++) begin
      pos = pos + 1'b1;
      if ((pos & (pos - 1'b1)) == '0) begin
        pos = pos + 1'b1;
      end
    end
    return pos;
  endfunction

  function automatic logic [ham_w-1:0] ham_bits(input logic [data_w-1:0] d);
    logic [ham_w-1:0] h;
    h = '0;
    for (int i = 0; i < data_w; i++) begin
      if (d[i]) begin
        h = h ^ data_pos(i);
      end
    end
    return h;
  endfunction

  localparam logic [ham_w-1:0] last_pos = data_pos(data_w - 1);

  logic [ham_w-1:0]  enc_ham;
  logic              rd_ecc_q;
  logic [data_w-1:0] raw_data;
  logic [chk_w-1:0]  raw_chk;
  logic [ham_w-1:0]  syndrome;
  logic              parity_odd;
  logic [data_w-1:0] fixed_data;
  logic              single_err;
  logic              double_err;
  rram_result_t      result_nxt;

  // Write path
  assign enc_ham  = ham_bits(cmd_in.data);
  assign enc_word = cmd_in.use_ecc ? {^{enc_ham, cmd_in.data}, enc_ham, cmd_in.data}
                                   : {{chk_w{1'b0}}, cmd_in.data};
  assign cmd_out  = cmd_in;

  // Read path syndrome
  assign raw_data   = raw_word[data_w-1:0];
  assign raw_chk    = raw_word[word_w-1:data_w];
  assign syndrome   = ham_bits(raw_data) ^ raw_chk[ham_w-1:0];
  assign parity_odd = ^raw_word;

  // Odd parity with a syndrome past the last slot is a wider error
  assign single_err = parity_odd && (syndrome <= last_pos);
  assign double_err = (!parity_odd && (syndrome != '0)) || (parity_odd && (syndrome > last_pos));

  always_comb begin
    fixed_data = raw_data;
    for (int i = 0; i < data_w; i++) begin
      if (syndrome == data_pos(i)) begin
        fixed_data[i] = ~raw_data[i];
      end
    end
  end

  always_comb begin
    result_nxt.data          = raw_data;
    result_nxt.corrected     = 1'b0;
    result_nxt.uncorrectable = 1'b0;
    if (rd_ecc_q) begin
      result_nxt.data          = single_err ? fixed_data : raw_data;
      result_nxt.corrected     = single_err;
      result_nxt.uncorrectable = double_err;
    end
  end

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ecc_q <= 1'b0;
      result   <= '0;
    end else begin
      if (cmd_in.go) begin
        rd_ecc_q <= cmd_in.use_ecc;
      end
      if (raw_valid) begin
        result <= result_nxt;
      end
    end
  end

endmodule

// ==== verilog/array_sequencer.sv ====
`timescale 1ns/10ps
// setup_cyc and pulse_cyc must be at least 1, and read latency is set by the macro through sa_rdy
module array_sequencer
  import rram_cfg_pkg::*;
  import rram_analog_pkg::*;
#(
  parameter int unsigned setup_cyc = 4,
  parameter int unsigned pulse_cyc = 3
) (
  input  logic              mclk,
  input  logic              rst_n,
  input  rram_cmd_t         cmd,
  input  logic [word_w-1:0] enc_word,
  input  sense_t            sense,
  input  logic              byp,
  input  analog_ctrl_t      pad_ctrl,
  output analog_ctrl_t      ana,
  output logic [word_w-1:0] raw_word,
  output logic              raw_valid,
  output logic              busy,
  output logic              heartbeat
);

  localparam int unsigned max_cyc = (setup_cyc > pulse_cyc) ? setup_cyc : pulse_cyc;
  localparam int cnt_w = (max_cyc > 1) ? $clog2(max_cyc) : 1;

  typedef enum logic [2:0] {
    st_idle,
    st_setup,
    st_pulse,
    st_sense,
    st_capture
  } seq_state_e;

  seq_state_e        state;
  logic [cnt_w-1:0]  cnt;
  logic              rd_q;
  logic              idle_like;
  logic [addr_w-1:0] addr_q;
  logic [word_w-1:0] word_q;
  logic [word_w-1:0] raw_q;
  analog_ctrl_t      seq_ctrl;

  // Capture cycle is not busy and takes a new go like idle
  assign idle_like = (state == st_idle) || (state == st_capture);

  //////////////////////////////
  // Operation FSM
  //////////////////////////////

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      cnt   <= '0;
      rd_q  <= 1'b0;
    end else begin
      case (state)
        st_idle, st_capture: begin
          state <= st_idle;
          if (cmd.go) begin
            state <= st_setup;
            cnt   <= cnt_w'(setup_cyc - 1);
            rd_q  <= cmd.rd;
          end
        end
        st_setup: begin
          if (cnt == '0) begin
            if (rd_q) begin
              state <= st_sense;
            end else begin
              state <= st_pulse;
              cnt   <= cnt_w'(pulse_cyc - 1);
            end
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        st_pulse: begin
          if (cnt == '0) begin
            state <= st_idle;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        // Held open until the macro answers
        st_sense: begin
          if (sense.sa_rdy) begin
            state <= st_capture;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge mclk) begin
    if (idle_like && cmd.go) begin
      addr_q <= cmd.addr;
      word_q <= enc_word;
    end
    if ((state == st_sense) && sense.sa_rdy) begin
      raw_q <= sense.sa_do;
    end
  end

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      heartbeat <= 1'b0;
    end else begin
      heartbeat <= ~heartbeat;
    end
  end

  //////////////////////////////
  // Macro controls
  //////////////////////////////

  // Live command values while idle so address and data appear in the go cycle
  always_comb begin
    seq_ctrl.rram_addr = idle_like ? cmd.addr : addr_q;
    seq_ctrl.di        = idle_like ? enc_word : word_q;
    seq_ctrl.we        = (state == st_pulse);
    seq_ctrl.wl_en     = (state == st_pulse) || (state == st_sense);
    seq_ctrl.bl_en     = (state == st_pulse);
    seq_ctrl.sl_en     = (state == st_sense);
    seq_ctrl.sa_en     = (state == st_sense);
  end

  assign ana       = byp ? pad_ctrl : seq_ctrl;
  assign busy      = !idle_like;
  assign raw_valid = (state == st_capture);
  assign raw_word  = raw_q;

endmodule

// ==== verilog/rram_top.sv ====
`timescale 1ns/10ps
// mclk is a free-running input and must run at least 8 times faster than sclk
module rram_top
  import rram_cfg_pkg::*;
  import rram_analog_pkg::*;
#(
  parameter int unsigned setup_cyc = 4,
  parameter int unsigned pulse_cyc = 3
) (
  input  logic         mclk,
  input  logic         rst_n,
  input  logic         sclk,
  input  logic         sc,
  input  logic         mosi,
  input  sense_t       sense,
  input  logic         byp,
  input  analog_ctrl_t pad_ctrl,
  output logic         miso,
  output analog_ctrl_t ana,
  output logic         rram_busy,
  output logic         heartbeat
);

  rram_cmd_t         spi_cmd;
  rram_cmd_t         seq_cmd;
  logic [word_w-1:0] enc_word;
  logic [word_w-1:0] raw_word;
  logic              raw_valid;
  rram_result_t      result;

  spi_cmd_port spi_cmd_port_inst (
    .mclk   (mclk),
    .rst_n  (rst_n),
    .sclk   (sclk),
    .sc     (sc),
    .mosi   (mosi),
    .busy   (rram_busy),
    .result (result),
    .miso   (miso),
    .cmd    (spi_cmd)
  );

  ecc_codec ecc_codec_inst (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .cmd_in    (spi_cmd),
    .raw_word  (raw_word),
    .raw_valid (raw_valid),
    .cmd_out   (seq_cmd),
    .enc_word  (enc_word),
    .result    (result)
  );

  array_sequencer #(
    .setup_cyc (setup_cyc),
    .pulse_cyc (pulse_cyc)
  ) array_sequencer_inst (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .cmd       (seq_cmd),
    .enc_word  (enc_word),
    .sense     (sense),
    .byp       (byp),
    .pad_ctrl  (pad_ctrl),
    .ana       (ana),
    .raw_word  (raw_word),
    .raw_valid (raw_valid),
    .busy      (rram_busy),
    .heartbeat (heartbeat)
  );

endmodule

// ==== testbench/rram_array_model.sv ====
`timescale 1ns/10ps
// Unwritten words read back as X and the sense delay cycles through 2 to 6 mclk
module rram_array_model
  import rram_cfg_pkg::*;
  import rram_analog_pkg::*;
(
  input  logic              mclk,
  input  logic              rst_n,
  input  analog_ctrl_t      ana,
  input  logic [word_w-1:0] flip_mask,
  output sense_t            sense
);

  logic [word_w-1:0] mem [0:(1 << addr_w) - 1];
  logic [2:0]        wait_cnt;
  logic [2:0]        delay_sel;
  logic [2:0]        delay;

  // Next answer delay, 2 to 6 cycles
  assign delay = 3'd2 + delay_sel;

  always_ff @(posedge mclk) begin
    if (ana.we && ana.wl_en) begin
      mem[ana.rram_addr] <= ana.di;
    end
  end

  // One sa_rdy pulse per delay while sa_en stays high
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      sense     <= '0;
      wait_cnt  <= '0;
      delay_sel <= '0;
    end else begin
      sense.sa_rdy <= 1'b0;
      if (!ana.sa_en || sense.sa_rdy) begin
        wait_cnt <= '0;
      end else if (wait_cnt == (delay - 3'd1)) begin
        sense.sa_rdy <= 1'b1;
        sense.sa_do  <= mem[ana.rram_addr] ^ flip_mask;
        wait_cnt     <= '0;
        delay_sel    <= (delay_sel == 3'd4) ? 3'd0 : delay_sel + 3'd1;
      end else begin
        wait_cnt <= wait_cnt + 3'd1;
      end
    end
  end

endmodule

// ==== testbench/rram_top_props.sv ====
`timescale 1ns/10ps
// Rules hold outside bypass only, except that rram_busy must be low in reset
module rram_top_props
  import rram_analog_pkg::*;
(
  input logic         mclk,
  input logic         rst_n,
  input logic         byp,
  input analog_ctrl_t ana,
  input logic         rram_busy
);

  logic any_en;

  assign any_en = ana.we | ana.wl_en | ana.bl_en | ana.sl_en | ana.sa_en;

  sense_write_apart: assert property (
    @(posedge mclk) disable iff (!rst_n) !byp |-> !(ana.sa_en && ana.we)
  ) else $error("sa_en and we high together");

  write_needs_wordline: assert property (
    @(posedge mclk) disable iff (!rst_n) (!byp && ana.we) |-> ana.wl_en
  ) else $error("we high without wl_en");

  idle_enables_low: assert property (
    @(posedge mclk) disable iff (!rst_n) (!byp && !rram_busy) |-> !any_en
  ) else $error("macro enable high while rram_busy is low");

  reset_not_busy: assert property (
    @(posedge mclk) !rst_n |-> !rram_busy
  ) else $error("rram_busy high during reset");

endmodule

// ==== testbench/tb_rram_top.sv ====
`timescale 1ns/10ps
// Reads expect the table to have written their address first, and SPI runs 4 mclk per phase
module tb_rram_top
  import rram_cfg_pkg::*;
  import rram_analog_pkg::*;
();

  localparam int unsigned setup_cyc = 4;
  localparam int unsigned pulse_cyc = 3;
  localparam int reset_cyc    = 4;
  localparam int cond_busy_hi = 0;
  localparam int cond_busy_lo = 1;
  localparam int cond_sense   = 2;

  typedef struct packed {
    logic              rd;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic              use_ecc;
    logic [1:0]        flips;
    logic [data_w-1:0] exp_data;
    logic              exp_corr;
    logic              exp_unc;
  } row_t;

  logic              mclk;
  logic              rst_n;
  logic              sclk;
  logic              sc;
  logic              mosi;
  logic              miso;
  logic              byp;
  logic              rram_busy;
  logic              heartbeat;
  analog_ctrl_t      pad_ctrl;
  analog_ctrl_t      ana;
  sense_t            sense;
  logic [word_w-1:0] flip_mask;

  row_t              stim_q [$];
  logic [data_w-1:0] rand_words [3];
  integer            seed;
  int                err_count;
  int                tests_run;
  int                tests_bad;
  bit                timeout_hit;

  rram_top #(
    .setup_cyc (setup_cyc),
    .pulse_cyc (pulse_cyc)
  ) rram_top_inst (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .sc        (sc),
    .mosi      (mosi),
    .sense     (sense),
    .byp       (byp),
    .pad_ctrl  (pad_ctrl),
    .miso      (miso),
    .ana       (ana),
    .rram_busy (rram_busy),
    .heartbeat (heartbeat)
  );

  rram_array_model array_model_inst (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .ana       (ana),
    .flip_mask (flip_mask),
    .sense     (sense)
  );

  bind rram_top rram_top_props rram_top_props_inst (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .byp       (byp),
    .ana       (ana),
    .rram_busy (rram_busy)
  );

  always #20 mclk = ~mclk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic tick();
    @(posedge mclk);
    #2;
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      err_count++;
    end
  endtask

  function automatic logic any_en();
    return ana.we | ana.wl_en | ana.bl_en | ana.sl_en | ana.sa_en;
  endfunction

  function automatic logic write_en();
    return ana.we & ana.wl_en & ana.bl_en & ~ana.sl_en & ~ana.sa_en;
  endfunction

  function automatic logic cond_met(input int cond);
    case (cond)
      cond_busy_hi: return rram_busy === 1'b1;
      cond_busy_lo: return rram_busy === 1'b0;
      default:      return ana.sa_en === 1'b1;
    endcase
  endfunction

  task automatic wait_for(input int cond, input int limit, input string what);
    int n;
    n = 0;
    while (!cond_met(cond) && (n < limit)) begin
      tick();
      n++;
    end
    if (!cond_met(cond)) begin
      $display("Timeout after %0d cycles waiting for %s at %0t ns", limit, what, $time);
      timeout_hit = 1'b1;
      err_count++;
    end
  endtask

  // Mode 0 with MSB first and miso sampled just before each rising sclk
  task automatic spi_frame(input logic [op_w-1:0] op, input logic [pay_w-1:0] pay,
                           output logic [frame_w-1:0] rx);
    logic [frame_w-1:0] tx;
    tx = {op, pay};
    repeat (4) tick();
    sc = 1'b0;
    repeat (4) tick();
    for (int i = frame_w - 1; i >= 0; i--) begin
      mosi = tx[i];
      repeat (4) tick();
      rx[i] = miso;
      sclk = 1'b1;
      repeat (4) tick();
      sclk = 1'b0;
    end
    repeat (4) tick();
    sc = 1'b1;
  endtask

  function automatic logic [pay_w-1:0] ctrl_payload(input logic rd, input logic use_ecc);
    logic [pay_w-1:0] p;
    p = '0;
    p[ctrl_start_bit] = 1'b1;
    p[ctrl_rd_bit]    = rd;
    p[ctrl_ecc_bit]   = use_ecc;
    return p;
  endfunction

  function automatic logic [word_w-1:0] flip_mask_for(input int idx, input logic [1:0] flips);
    logic [word_w-1:0] m;
    m = '0;
    if (flips != 2'd0) begin
      m[(idx * 5) % word_w] = 1'b1;
    end
    if (flips == 2'd2) begin
      m[(idx * 5 + 7) % word_w] = 1'b1;
    end
    return m;
  endfunction

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  function automatic void add_write(input logic [addr_w-1:0] addr,
                                    input logic [data_w-1:0] data, input logic use_ecc);
    row_t r;
    r = '0;
    r.addr    = addr;
    r.data    = data;
    r.use_ecc = use_ecc;
    stim_q.push_back(r);
  endfunction

  function automatic void add_read(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                                   input logic use_ecc, input logic [1:0] flips);
    row_t              r;
    logic [word_w-1:0] m;
    m = flip_mask_for(stim_q.size(), flips);
    r = '0;
    r.rd       = 1'b1;
    r.addr     = addr;
    r.data     = data;
    r.use_ecc  = use_ecc;
    r.flips    = flips;
    // Raw data passes through without ECC and on a double error
    r.exp_data = (!use_ecc || (flips == 2'd2)) ? data ^ m[data_w-1:0] : data;
    r.exp_corr = use_ecc && (flips == 2'd1);
    r.exp_unc  = use_ecc && (flips == 2'd2);
    stim_q.push_back(r);
  endfunction

  task automatic build_table();
    for (int i = 0; i < 3; i++) begin
      rand_words[i] = data_w'($random(seed));
    end
    add_write(12'h010, 16'ha5c3, 1'b0);
    add_write(12'h011, rand_words[0], 1'b0);
    add_read(12'h010, 16'ha5c3, 1'b0, 2'd0);
    add_read(12'h011, rand_words[0], 1'b0, 2'd0);
    add_write(12'h200, rand_words[1], 1'b1);
    add_read(12'h200, rand_words[1], 1'b1, 2'd0);
    add_read(12'h200, rand_words[1], 1'b1, 2'd1);
    add_write(12'h3ff, 16'h1234, 1'b1);
    add_read(12'h3ff, 16'h1234, 1'b1, 2'd2);
    add_write(12'h0a5, rand_words[2], 1'b1);
    add_read(12'h0a5, rand_words[2], 1'b1, 2'd1);
    add_read(12'h010, 16'ha5c3, 1'b0, 2'd0);
    // Row 12 flips a check bit
    add_read(12'h200, rand_words[1], 1'b1, 2'd1);
  endtask

  //////////////////////////////
  // Operations
  //////////////////////////////

  task automatic run_write(input row_t r);
    logic [frame_w-1:0] rx;
    int                 n_setup;
    int                 n_pulse;
    spi_frame(op_wr_addr, pay_w'(r.addr), rx);
    spi_frame(op_wr_data, pay_w'(r.data), rx);
    spi_frame(op_ctrl, ctrl_payload(1'b0, r.use_ecc), rx);
    wait_for(cond_busy_hi, 40, "rram_busy to rise");
    if (timeout_hit) begin
      return;
    end
    check_value(ana.rram_addr, r.addr, "address during setup");
    check_value(ana.di[data_w-1:0], r.data, "data bits during setup");
    if (!r.use_ecc) begin
      check_value(ana.di[word_w-1:data_w], 0, "check bits without ECC");
    end
    n_setup = 0;
    n_pulse = 0;
    while (rram_busy && !any_en() && (n_setup < 64)) begin
      n_setup++;
      tick();
    end
    while (rram_busy && write_en() && (n_pulse < 64)) begin
      n_pulse++;
      tick();
    end
    check_value(n_setup, setup_cyc, "setup cycles");
    check_value(n_pulse, pulse_cyc, "pulse cycles");
    check_value(rram_busy, 1'b0, "rram_busy after pulse");
    check_value(any_en(), 1'b0, "enables after pulse");
  endtask

  task automatic run_read(input row_t r, input logic [word_w-1:0] mask, input logic watch_sense);
    logic [frame_w-1:0] rx;
    spi_frame(op_wr_addr, pay_w'(r.addr), rx);
    flip_mask = mask;
    spi_frame(op_ctrl, ctrl_payload(1'b1, r.use_ecc), rx);
    wait_for(cond_busy_hi, 40, "rram_busy to rise");
    if (watch_sense && !timeout_hit) begin
      wait_for(cond_sense, 40, "sa_en");
    end
    if (!timeout_hit) begin
      wait_for(cond_busy_lo, 40, "rram_busy to fall");
    end
    flip_mask = '0;
    if (timeout_hit) begin
      return;
    end
    spi_frame(op_nop, '0, rx);
    check_value(rx[frame_w-1], 1'b0, "status busy");
    check_value(rx[frame_w-2], r.exp_corr, "corrected flag");
    check_value(rx[frame_w-3], r.exp_unc, "uncorrectable flag");
    check_value(rx[frame_w-4:data_w], 0, "status padding");
    check_value(rx[data_w-1:0], r.exp_data, "read data");
  endtask

  task automatic run_bypass();
    analog_ctrl_t pad_vals [3];
    row_t         r;
    pad_vals[0] = '{rram_addr: 12'hf01, di: 22'h2aaaaa, we: 1'b1, wl_en: 1'b1,
                    bl_en: 1'b0, sl_en: 1'b0, sa_en: 1'b0};
    pad_vals[1] = '{rram_addr: 12'hf02, di: 22'h155555, we: 1'b0, wl_en: 1'b0,
                    bl_en: 1'b1, sl_en: 1'b1, sa_en: 1'b0};
    pad_vals[2] = '{rram_addr: 12'hf03, di: 22'h3c0f0f, we: 1'b0, wl_en: 1'b1,
                    bl_en: 1'b0, sl_en: 1'b0, sa_en: 1'b1};
    for (int i = 0; i < 3; i++) begin
      pad_ctrl = pad_vals[i];
      byp      = 1'b1;
      #1;
      check_value(ana, pad_vals[i], "ana under bypass");
      tick();
    end
    // Pads hold a sense of the word written at 12'h200
    pad_ctrl = '{rram_addr: 12'h200, di: '0, we: 1'b0, wl_en: 1'b1,
                 bl_en: 1'b0, sl_en: 1'b1, sa_en: 1'b1};
    r = '0;
    r.rd       = 1'b1;
    r.addr     = 12'h200;
    r.use_ecc  = 1'b1;
    r.exp_data = rand_words[1];
    run_read(r, '0, 1'b0);
    byp      = 1'b0;
    pad_ctrl = '0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: ERROR", tests_run, name);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    row_t r;
    int   errs_before;
    logic prev_hb;
    mclk        = 1'b0;
    rst_n       = 1'b0;
    sclk        = 1'b0;
    sc          = 1'b1;
    mosi        = 1'b0;
    byp         = 1'b0;
    pad_ctrl    = '0;
    flip_mask   = '0;
    err_count   = 0;
    tests_run   = 0;
    tests_bad   = 0;
    timeout_hit = 1'b0;
    seed        = 32'h55d7;
    build_table();

    errs_before = err_count;
    repeat (reset_cyc) tick();
    check_value(rram_busy, 1'b0, "rram_busy in reset");
    check_value(heartbeat, 1'b0, "heartbeat in reset");
    rst_n = 1'b1;
    tick();
    check_value(rram_busy, 1'b0, "rram_busy after reset");
    check_value(any_en(), 1'b0, "enables after reset");
    for (int i = 0; i < 8; i++) begin
      prev_hb = heartbeat;
      tick();
      check_value(heartbeat, !prev_hb, "heartbeat toggle");
    end
    report_test("reset state", errs_before);

    for (int i = 0; i < stim_q.size(); i++) begin
      if (!timeout_hit) begin
        errs_before = err_count;
        r = stim_q[i];
        if (r.rd) begin
          run_read(r, flip_mask_for(i, r.flips), 1'b1);
        end else begin
          run_write(r);
        end
        report_test($sformatf("%s %h", r.rd ? "read" : "write", r.addr), errs_before);
      end
    end

    if (!timeout_hit) begin
      errs_before = err_count;
      run_bypass();
      report_test("pad bypass", errs_before);
    end

    $display("Summary: %0d tests, %0d with errors, %0d failed checks",
             tests_run, tests_bad, err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/rram_cfg_pkg.sv
verilog/rram_analog_pkg.sv
verilog/spi_cmd_port.sv
verilog/ecc_codec.sv
verilog/array_sequencer.sv
verilog/rram_top.sv
testbench/rram_array_model.sv
testbench/rram_top_props.sv
testbench/tb_rram_top.sv
